/* Makefile */
TOP = tb_mgmt_core

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns --top-module $(TOP) \
		-f vlog.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

/* logic/core_clocking.sv */
/*
 * Core clocking block
 * Two-flop reset synchronizer with software reset
 * User clock divider
 */
`timescale 1ns/1ns

module core_clocking
	import mgmt_pkg::*;
(
	input  logic     clock,
	input  logic     arst_n_i,
	input  logic     soft_reset_i,
	input  clk_div_t user_clk_div_i,
	output logic     core_rstn_o,
	output logic     user_clk_o
);

	logic [1:0] rst_sync;
	clk_div_t   div_q;
	clk_div_t   div_cnt;

	// Assert asynchronously, release two clocks after both sources clear
	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rst_sync <= 2'b00;
		end else if (soft_reset_i) begin
			rst_sync <= 2'b00;
		end else begin
			rst_sync <= {rst_sync[0], 1'b1};
		end
	end

	assign core_rstn_o = rst_sync[1];

	// Toggle every div_q clocks so each phase lasts div_q periods
	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			div_q      <= 3'd0;
			div_cnt    <= 3'd0;
			user_clk_o <= 1'b0;
		end else if (user_clk_div_i != div_q) begin
			// New divisor restarts from a low phase
			div_q      <= user_clk_div_i;
			div_cnt    <= 3'd0;
			user_clk_o <= 1'b0;
		end else if (div_q == 3'd0) begin
			// Divisor 0 parks the user clock low
			div_cnt    <= 3'd0;
			user_clk_o <= 1'b0;
		end else if (div_cnt == div_q - 3'd1) begin
			div_cnt    <= 3'd0;
			user_clk_o <= ~user_clk_o;
		end else begin
			div_cnt <= div_cnt + 3'd1;
		end
	end

endmodule

/* logic/hk_regs.sv */
/*
 * Housekeeping configuration registers
 * Ack side of the four-phase req/ack handshake
 * Read decode of mask revision, control, pad and interrupt status bytes
 */
`timescale 1ns/1ns

module hk_regs
	import mgmt_pkg::*;
#(
	parameter int IO_PADS = 16
) (
	input  logic      clock,
	input  logic      arst_n_i,
	input  logic      req_i,
	input  hk_req_t   req_data_i,
	output logic      ack_o,
	output reg_data_t rdata_o,
	input  mask_rev_t mask_rev_i,
	input  irq_vec_t  user_irq_i,
	output mgmt_cfg_t cfg_o
);

	// Pads at or above IO_PADS stay low and disabled
	localparam pad_vec_t PAD_USED = 16'hFFFF >> (16 - IO_PADS);

	localparam mgmt_cfg_t CFG_RST = '{
		user_clk_div:   3'd0,
		soft_reset:     1'b0,
		pass_thru_user: 1'b0,
		sdo_override:   1'b0,
		irq_ena:        3'd0,
		pad_out:        16'h0000,
		pad_oeb:        16'hFFFF
	};

	mgmt_cfg_t cfg_q;
	reg_data_t rd_mux;
	logic      access;
	reg_data_t wdata;

	// Only the first cycle of a request, before ack answers it
	assign access = req_i & ~ack_o;
	assign wdata  = req_data_i.wdata;

	always_comb begin
		rd_mux = 8'h00;
		case (req_data_i.addr)
			ADDR_MASK_REV0:  rd_mux = mask_rev_i[7:0];
			ADDR_MASK_REV1:  rd_mux = mask_rev_i[15:8];
			ADDR_MASK_REV2:  rd_mux = mask_rev_i[23:16];
			ADDR_MASK_REV3:  rd_mux = mask_rev_i[31:24];
			ADDR_CLK_CTRL: begin
				rd_mux[2:0]             = cfg_q.user_clk_div;
				rd_mux[CLK_SOFT_RST_BIT] = cfg_q.soft_reset;
			end
			ADDR_IO_CTRL: begin
				rd_mux[IO_PASS_THRU_BIT] = cfg_q.pass_thru_user;
				rd_mux[IO_SDO_OVR_BIT]   = cfg_q.sdo_override;
			end
			ADDR_IRQ_ENA:    rd_mux[2:0] = cfg_q.irq_ena;
			ADDR_PAD_OUT_LO: rd_mux = cfg_q.pad_out[7:0];
			ADDR_PAD_OUT_HI: rd_mux = cfg_q.pad_out[15:8];
			ADDR_PAD_OEB_LO: rd_mux = cfg_q.pad_oeb[7:0];
			ADDR_PAD_OEB_HI: rd_mux = cfg_q.pad_oeb[15:8];
			// Raw interrupt lines, not masked by irq_ena
			ADDR_IRQ_STAT:   rd_mux[2:0] = user_irq_i;
			default:         rd_mux = 8'h00;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_o <= 1'b0;
			cfg_q <= CFG_RST;
		end else begin
			// Ack follows req by one clock in both directions
			ack_o <= req_i;
			if (access && req_data_i.we) begin
				case (req_data_i.addr)
					ADDR_CLK_CTRL: begin
						cfg_q.user_clk_div <= wdata[2:0];
						cfg_q.soft_reset   <= wdata[CLK_SOFT_RST_BIT];
					end
					ADDR_IO_CTRL: begin
						cfg_q.pass_thru_user <= wdata[IO_PASS_THRU_BIT];
						cfg_q.sdo_override   <= wdata[IO_SDO_OVR_BIT];
					end
					ADDR_IRQ_ENA:    cfg_q.irq_ena <= wdata[2:0];
					ADDR_PAD_OUT_LO: cfg_q.pad_out[7:0] <= wdata & PAD_USED[7:0];
					ADDR_PAD_OUT_HI: cfg_q.pad_out[15:8] <= wdata & PAD_USED[15:8];
					ADDR_PAD_OEB_LO: cfg_q.pad_oeb[7:0] <= wdata | ~PAD_USED[7:0];
					ADDR_PAD_OEB_HI: cfg_q.pad_oeb[15:8] <= wdata | ~PAD_USED[15:8];
					// Read-only and unmapped addresses
					default: cfg_q <= cfg_q;
				endcase
			end
		end
	end

	// Read data is captured with the request and held through ack
	always_ff @(posedge clock) begin
		if (access) begin
			rdata_o <= rd_mux;
		end
	end

	assign cfg_o = cfg_q;

endmodule

/* logic/hk_spi_slave.sv */
/*
 * Housekeeping SPI slave, mode 0, 16-bit frames MSB first
 * Two-flop pin synchronizers and SCK edge detection
 * Frame FSM issuing a read request per frame and a write request on writes
 * Read data shifted out on SDO after each SCK falling edge
 */
`timescale 1ns/1ns

module hk_spi_slave
	import mgmt_pkg::*;
(
	input  logic      clock,
	input  logic      arst_n_i,
	input  logic      spi_sck_i,
	input  logic      spi_csb_i,
	input  logic      spi_sdi_i,
	output logic      spi_sdo_o,
	output logic      spi_sdo_oeb_o,
	output logic      req_o,
	output hk_req_t   req_data_o,
	input  logic      ack_i,
	input  reg_data_t rdata_i
);

	// Pin order inside the sync vectors is {sck, csb, sdi}
	logic [2:0] pin_meta;
	logic [2:0] pin_sync;
	logic       sck_prev;
	logic       sck_s;
	logic       csb_s;
	logic       sdi_s;
	logic       sck_rise;
	logic       sck_fall;

	spi_state_e state;
	logic [2:0] bit_cnt;
	logic       wr_frame;
	logic       sdo_oeb_q;
	reg_data_t  rx_sr;
	reg_data_t  rx_next;
	reg_data_t  tx_sr;
	logic       byte_done;

	// CSB idles high so the synchronizer starts deselected
	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pin_meta <= 3'b010;
			pin_sync <= 3'b010;
			sck_prev <= 1'b0;
		end else begin
			pin_meta <= {spi_sck_i, spi_csb_i, spi_sdi_i};
			pin_sync <= pin_meta;
			sck_prev <= pin_sync[2];
		end
	end

	assign sck_s = pin_sync[2];
	assign csb_s = pin_sync[1];
	assign sdi_s = pin_sync[0];

	// Edges seen here are acted on three clocks after the pin moved
	assign sck_rise = sck_s & ~sck_prev;
	assign sck_fall = ~sck_s & sck_prev;

	assign rx_next = {rx_sr[6:0], sdi_s};
	assign byte_done = sck_rise && (bit_cnt == 3'd7);

	// Frame control
	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state     <= IDLE;
			bit_cnt   <= 3'd0;
			wr_frame  <= 1'b0;
			sdo_oeb_q <= 1'b1;
			req_o     <= 1'b0;
		end else if (csb_s && state != RD_REQ && state != WR_REQ) begin
			// Deselect aborts the frame, an open handshake is finished first
			state     <= IDLE;
			sdo_oeb_q <= 1'b1;
		end else begin
			case (state)
				IDLE: begin
					bit_cnt <= 3'd0;
					state   <= ADDR;
				end
				ADDR: begin
					if (sck_rise) begin
						bit_cnt <= bit_cnt + 3'd1;
					end
					if (byte_done) begin
						// First bit of the frame is the write flag
						wr_frame  <= rx_next[7];
						sdo_oeb_q <= rx_next[7];
						state     <= RD_REQ;
					end
				end
				RD_REQ: begin
					if (!req_o) begin
						// Never raise req over a trailing ack
						if (!ack_i) begin
							req_o <= 1'b1;
						end
					end else if (ack_i) begin
						req_o <= 1'b0;
						state <= DATA;
					end
				end
				DATA: begin
					if (sck_rise) begin
						bit_cnt <= bit_cnt + 3'd1;
					end
					if (byte_done) begin
						state <= wr_frame ? WR_REQ : DONE;
					end
				end
				WR_REQ: begin
					if (!req_o) begin
						if (!ack_i) begin
							req_o <= 1'b1;
						end
					end else if (ack_i) begin
						req_o <= 1'b0;
						state <= DONE;
					end
				end
				DONE: begin
					// Extra clocks are ignored until CSB rises
					state <= DONE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Shift registers and request payload
	always_ff @(posedge clock) begin
		if (sck_rise && (state == ADDR || state == DATA)) begin
			rx_sr <= rx_next;
		end
		// Read request carries the address, we stays low
		if (state == ADDR && byte_done) begin
			req_data_o.we    <= 1'b0;
			req_data_o.addr  <= rx_next[6:0];
			req_data_o.wdata <= 8'h00;
		end
		if (state == DATA && byte_done && wr_frame) begin
			req_data_o.we    <= 1'b1;
			req_data_o.wdata <= rx_next;
		end
		// First falling edge after the address byte keeps bit 7 on SDO
		if (state == RD_REQ && req_o && ack_i) begin
			tx_sr <= rdata_i;
		end else if (state == DATA && sck_fall && bit_cnt != 3'd0) begin
			tx_sr <= {tx_sr[6:0], 1'b0};
		end
	end

	assign spi_sdo_o = tx_sr[7];

	// Raw CSB keeps SDO released the moment the host deselects
	assign spi_sdo_oeb_o = sdo_oeb_q | spi_csb_i;

endmodule

/* logic/io_mux.sv */
/*
 * Management pad multiplexing
 * Pad output data and output-enable bars
 * User flash pass-through on pads 8 to 10 and SDO override
 */
`timescale 1ns/1ns

module io_mux
	import mgmt_pkg::*;
#(
	parameter int IO_PADS = 16
) (
	input  mgmt_cfg_t          cfg_i,
	input  logic               spi_csb_i,
	input  logic               spi_sck_i,
	input  logic               spi_sdi_i,
	input  logic               spi_sdo_i,
	input  logic               spi_sdo_oeb_i,
	output logic [IO_PADS-1:0] mgmt_out_data_o,
	output logic [IO_PADS-1:0] mgmt_oeb_o,
	output logic               sdo_o,
	output logic               sdo_oeb_o
);

	pad_vec_t pad_pre;

	// Flash pass-through replaces pad data on CSB, SCK and SDI pads
	always_comb begin
		pad_pre = cfg_i.pad_out;
		if (cfg_i.pass_thru_user) begin
			pad_pre[8]  = spi_csb_i;
			pad_pre[9]  = spi_sck_i;
			pad_pre[10] = spi_sdi_i;
		end
	end

	always_comb begin
		for (int i = 0; i < IO_PADS; i++) begin
			if (i < 2 || i >= IO_PADS - 2) begin
				// Edge pads go straight to the pad, always enabled
				mgmt_out_data_o[i] = cfg_i.pad_out[i];
				mgmt_oeb_o[i]      = 1'b0;
			end else begin
				// Shared pads drive 0 in place of high-Z when disabled
				mgmt_out_data_o[i] = cfg_i.pad_oeb[i] ? 1'b0 : pad_pre[i];
				mgmt_oeb_o[i]      = cfg_i.pad_oeb[i];
			end
		end
	end

	// Override hands SDO to pad_out bit 1
	assign sdo_o     = cfg_i.sdo_override ? cfg_i.pad_out[1] : spi_sdo_i;
	assign sdo_oeb_o = cfg_i.sdo_override ? 1'b0 : spi_sdo_oeb_i;

endmodule

/* logic/mgmt_core.sv */
/*
 * Management area top level
 * Housekeeping SPI slave and configuration registers
 * Pad multiplexing and core clocking
 */
`timescale 1ns/1ns

module mgmt_core
	import mgmt_pkg::*;
#(
	parameter int IO_PADS = 16
) (
	input  logic               clock,
	input  logic               arst_n_i,
	input  logic               spi_sck_i,
	input  logic               spi_csb_i,
	input  logic               spi_sdi_i,
	output logic               sdo_o,
	output logic               sdo_oeb_o,
	input  mask_rev_t          mask_rev_i,
	input  irq_vec_t           user_irq_i,
	output irq_vec_t           user_irq_ena_o,
	output logic [IO_PADS-1:0] mgmt_out_data_o,
	output logic [IO_PADS-1:0] mgmt_oeb_o,
	output logic               core_rstn_o,
	output logic               user_clk_o
);

	// Handshake between SPI front end and registers
	logic      req;
	logic      ack;
	hk_req_t   req_data;
	reg_data_t rdata;

	// SPI slave SDO before the override mux
	logic      spi_sdo;
	logic      spi_sdo_oeb;

	mgmt_cfg_t cfg;

	// SPI and registers run on arst_n_i so software reset cannot lock out the host
	hk_spi_slave u_hk_spi_slave (
		.clock         (clock),
		.arst_n_i      (arst_n_i),
		.spi_sck_i     (spi_sck_i),
		.spi_csb_i     (spi_csb_i),
		.spi_sdi_i     (spi_sdi_i),
		.spi_sdo_o     (spi_sdo),
		.spi_sdo_oeb_o (spi_sdo_oeb),
		.req_o         (req),
		.req_data_o    (req_data),
		.ack_i         (ack),
		.rdata_i       (rdata)
	);

	hk_regs #(
		.IO_PADS (IO_PADS)
	) u_hk_regs (
		.clock      (clock),
		.arst_n_i   (arst_n_i),
		.req_i      (req),
		.req_data_i (req_data),
		.ack_o      (ack),
		.rdata_o    (rdata),
		.mask_rev_i (mask_rev_i),
		.user_irq_i (user_irq_i),
		.cfg_o      (cfg)
	);

	io_mux #(
		.IO_PADS (IO_PADS)
	) u_io_mux (
		.cfg_i           (cfg),
		.spi_csb_i       (spi_csb_i),
		.spi_sck_i       (spi_sck_i),
		.spi_sdi_i       (spi_sdi_i),
		.spi_sdo_i       (spi_sdo),
		.spi_sdo_oeb_i   (spi_sdo_oeb),
		.mgmt_out_data_o (mgmt_out_data_o),
		.mgmt_oeb_o      (mgmt_oeb_o),
		.sdo_o           (sdo_o),
		.sdo_oeb_o       (sdo_oeb_o)
	);

	core_clocking u_core_clocking (
		.clock          (clock),
		.arst_n_i       (arst_n_i),
		.soft_reset_i   (cfg.soft_reset),
		.user_clk_div_i (cfg.user_clk_div),
		.core_rstn_o    (core_rstn_o),
		.user_clk_o     (user_clk_o)
	);

	assign user_irq_ena_o = cfg.irq_ena;

endmodule

/* logic/mgmt_pkg.sv */
/*
 * Shared types and constants of the management core
 * Plain vector types for register, pad, divisor and interrupt widths
 * Housekeeping register map and control bit positions
 * Request struct, configuration struct and SPI slave state encoding
 */
package mgmt_pkg;

	// Widths that carry a meaning
	typedef logic [6:0]  reg_addr_t;
	typedef logic [7:0]  reg_data_t;
	typedef logic [2:0]  clk_div_t;
	typedef logic [2:0]  irq_vec_t;
	typedef logic [15:0] pad_vec_t;
	typedef logic [31:0] mask_rev_t;

	// Register map, mask revision is read-only and LSB first
	localparam reg_addr_t ADDR_MASK_REV0  = 7'h00;
	localparam reg_addr_t ADDR_MASK_REV1  = 7'h01;
	localparam reg_addr_t ADDR_MASK_REV2  = 7'h02;
	localparam reg_addr_t ADDR_MASK_REV3  = 7'h03;
	localparam reg_addr_t ADDR_CLK_CTRL   = 7'h04;
	localparam reg_addr_t ADDR_IO_CTRL    = 7'h05;
	localparam reg_addr_t ADDR_IRQ_ENA    = 7'h06;
	localparam reg_addr_t ADDR_PAD_OUT_LO = 7'h08;
	localparam reg_addr_t ADDR_PAD_OUT_HI = 7'h09;
	localparam reg_addr_t ADDR_PAD_OEB_LO = 7'h0A;
	localparam reg_addr_t ADDR_PAD_OEB_HI = 7'h0B;
	localparam reg_addr_t ADDR_IRQ_STAT   = 7'h0C;

	// Single-bit controls inside clk_ctrl and io_ctrl
	localparam int CLK_SOFT_RST_BIT = 7;
	localparam int IO_PASS_THRU_BIT = 0;
	localparam int IO_SDO_OVR_BIT   = 1;

	// One register access from the SPI front end
	typedef struct packed {
		logic      we;
		reg_addr_t addr;
		reg_data_t wdata;
	} hk_req_t;

	// Configuration state seen by the pad mux and the clocking block
	typedef struct packed {
		clk_div_t user_clk_div;
		logic     soft_reset;
		logic     pass_thru_user;
		logic     sdo_override;
		irq_vec_t irq_ena;
		pad_vec_t pad_out;
		pad_vec_t pad_oeb;
	} mgmt_cfg_t;

	typedef enum logic [2:0] {
		IDLE,
		ADDR,
		RD_REQ,
		DATA,
		WR_REQ,
		DONE
	} spi_state_e;

endpackage

/* tb/mgmt_core_asserts.sv */
/*
 * Concurrent checks bound into the management core
 * Four-phase req/ack handshake rules
 * Shared pads drive 0 when disabled, SDO override and release
 * Core reset held low under software reset
 */
`timescale 1ns/1ns

module mgmt_core_asserts
	import mgmt_pkg::*;
#(
	parameter int IO_PADS = 16
) (
	input logic               clock,
	input logic               arst_n_i,
	input logic               req_i,
	input logic               ack_i,
	input hk_req_t            req_data_i,
	input mgmt_cfg_t          cfg_i,
	input logic               spi_csb_i,
	input logic               sdo_i,
	input logic               sdo_oeb_i,
	input logic [IO_PADS-1:0] pad_data_i,
	input logic               core_rstn_i
);

	// Pads between the two edge pairs
	localparam logic [IO_PADS-1:0] SHARED_PADS = {2'b00, {(IO_PADS - 4){1'b1}}, 2'b00};

	logic soft_reset;

	assign soft_reset = cfg_i.soft_reset;

	// Ack only answers a req seen on the clock before
	ack_follows_req: assert property (@(posedge clock) disable iff (!arst_n_i)
		$rose(ack_i) |-> $past(req_i))
		else $error("ack rose without a pending req");

	// Payload frozen for the whole request
	req_data_held: assert property (@(posedge clock) disable iff (!arst_n_i)
		($past(req_i) && req_i) |-> $stable(req_data_i))
		else $error("req_data changed while req was high");

	// No new request over a trailing ack
	req_waits_ack: assert property (@(posedge clock) disable iff (!arst_n_i)
		$rose(req_i) |-> !$past(ack_i))
		else $error("req rose while ack was still high");

	disabled_pads_low: assert property (@(posedge clock) disable iff (!arst_n_i)
		(pad_data_i & cfg_i.pad_oeb[IO_PADS-1:0] & SHARED_PADS) == '0)
		else $error("a disabled shared pad drives 1");

	sdo_override_drive: assert property (@(posedge clock) disable iff (!arst_n_i)
		cfg_i.sdo_override |-> (!sdo_oeb_i && sdo_i == cfg_i.pad_out[1]))
		else $error("SDO override does not drive pad_out bit 1");

	// Deselected host means SDO released
	sdo_released: assert property (@(posedge clock) disable iff (!arst_n_i)
		(!cfg_i.sdo_override && spi_csb_i) |-> sdo_oeb_i)
		else $error("SDO enabled while CSB is high");

	soft_reset_hold: assert property (@(posedge clock) disable iff (!arst_n_i)
		$past(soft_reset) |-> !core_rstn_i)
		else $error("core_rstn_o high during software reset");

endmodule

bind mgmt_core mgmt_core_asserts #(
	.IO_PADS (IO_PADS)
) u_mgmt_core_asserts (
	.clock       (clock),
	.arst_n_i    (arst_n_i),
	.req_i       (req),
	.ack_i       (ack),
	.req_data_i  (req_data),
	.cfg_i       (cfg),
	.spi_csb_i   (spi_csb_i),
	.sdo_i       (sdo_o),
	.sdo_oeb_i   (sdo_oeb_o),
	.pad_data_i  (mgmt_out_data_o),
	.core_rstn_i (core_rstn_o)
);

/* tb/tb_mgmt_core.sv */
/*
 * Testbench for the management core
 * Clock, reset, SPI host frame tasks and LCG data source
 * Readback, pad, pass-through, interrupt and clocking checks
 * Watchdog and final verdict
 */
`timescale 1ns/1ns

module tb_mgmt_core
	import mgmt_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	localparam int HALF_SCK   = 8;
	// CSB setup and hold plus 16 bits of two half periods each
	localparam int FRAME_CLKS  = (2 * 16 + 4) * HALF_SCK;
	localparam int NUM_FRAMES  = 25;
	localparam int WATCHDOG_NS = 2 * NUM_FRAMES * FRAME_CLKS * CLK_PERIOD;
	localparam int USER_DIV    = 3;
	localparam mask_rev_t MASK_REV  = 32'hA5C3_1E42;
	localparam pad_vec_t  EDGE_PADS = 16'hC003;

	logic      clock = 1'b0;
	logic      arst_n;
	logic      spi_sck;
	logic      spi_csb;
	logic      spi_sdi;
	logic      sdo;
	logic      sdo_oeb;
	mask_rev_t mask_rev;
	irq_vec_t  user_irq;
	irq_vec_t  user_irq_ena;
	pad_vec_t  mgmt_out_data;
	pad_vec_t  mgmt_oeb;
	logic      core_rstn;
	logic      user_clk;

	logic [31:0] lcg_state;
	logic        mirror_check;
	// Register values as the host last wrote them
	pad_vec_t    pad_out_model;
	pad_vec_t    pad_oeb_model;

	mgmt_core #(
		.IO_PADS (16)
	) u_mgmt_core (
		.clock           (clock),
		.arst_n_i        (arst_n),
		.spi_sck_i       (spi_sck),
		.spi_csb_i       (spi_csb),
		.spi_sdi_i       (spi_sdi),
		.sdo_o           (sdo),
		.sdo_oeb_o       (sdo_oeb),
		.mask_rev_i      (mask_rev),
		.user_irq_i      (user_irq),
		.user_irq_ena_o  (user_irq_ena),
		.mgmt_out_data_o (mgmt_out_data),
		.mgmt_oeb_o      (mgmt_oeb),
		.core_rstn_o     (core_rstn),
		.user_clk_o      (user_clk)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	// LCG bits 23:16 mix better than the low bits
	function automatic reg_data_t lcg_byte();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	task automatic report_mismatch(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		$display("Test failed");
		$fatal(1, "Stopping at the first failed check");
	endtask

	// Pads 8, 9, 10 carry CSB, SCK, SDI under pass-through
	task automatic verify_pin_mirror();
		assert (mgmt_out_data[10:8] == {spi_sdi, spi_sck, spi_csb})
		else report_mismatch($sformatf("pads 10:8 are %b, SPI pins are %b",
			mgmt_out_data[10:8], {spi_sdi, spi_sck, spi_csb}));
	endtask

	// Mode 0 frame with SDO sampled as SCK rises
	task automatic shift_frame(input logic [15:0] frame, output reg_data_t miso);
		miso = 8'h00;
		@(negedge clock);
		spi_csb = 1'b0;
		repeat (HALF_SCK) @(negedge clock);
		for (int i = 15; i >= 0; i--) begin
			spi_sdi = frame[i];
			repeat (HALF_SCK) @(negedge clock);
			if (mirror_check) begin
				verify_pin_mirror();
			end
			if (i < 8) begin
				miso[i] = sdo;
			end
			spi_sck = 1'b1;
			repeat (HALF_SCK) @(negedge clock);
			if (mirror_check) begin
				verify_pin_mirror();
			end
			spi_sck = 1'b0;
		end
		repeat (HALF_SCK) @(negedge clock);
		spi_csb = 1'b1;
		repeat (HALF_SCK) @(negedge clock);
	endtask

	task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
		reg_data_t ignored;
		shift_frame({1'b1, addr, data}, ignored);
	endtask

	task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
		shift_frame({1'b0, addr, 8'h00}, data);
	endtask

	task automatic expect_read(input reg_addr_t addr, input reg_data_t exp);
		reg_data_t got;
		read_reg(addr, got);
		assert (got == exp)
		else report_mismatch($sformatf("read of 0x%02h gave 0x%02h, expected 0x%02h",
			addr, got, exp));
	endtask

	// Edge pads always drive pad_out, shared pads only while enabled
	task automatic compare_pads();
		pad_vec_t exp_data;
		pad_vec_t exp_oeb;
		exp_data = pad_out_model & (EDGE_PADS | ~pad_oeb_model);
		exp_oeb  = pad_oeb_model & ~EDGE_PADS;
		assert (mgmt_out_data == exp_data && mgmt_oeb == exp_oeb)
		else report_mismatch($sformatf("pads %h/%h, expected %h/%h",
			mgmt_out_data, mgmt_oeb, exp_data, exp_oeb));
	endtask

	// Counts falling clock edges within one high phase of user_clk_o
	task automatic measure_user_clk_high(output int high_clks);
		int waited;
		high_clks = 0;
		waited    = 0;
		while (user_clk == 1'b1 && waited < 64) begin
			@(negedge clock);
			waited++;
		end
		while (user_clk == 1'b0 && waited < 64) begin
			@(negedge clock);
			waited++;
		end
		while (user_clk == 1'b1 && waited < 64) begin
			@(negedge clock);
			high_clks++;
			waited++;
		end
		assert (waited < 64)
		else report_mismatch("user_clk_o did not toggle within 64 clocks");
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within the watchdog time");
		$display("Test failed");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		reg_data_t out_lo;
		reg_data_t out_hi;
		reg_data_t oeb_lo;
		reg_data_t oeb_hi;
		reg_data_t irq_val;
		int        high_clks;
		arst_n        = 1'b0;
		spi_sck       = 1'b0;
		spi_csb       = 1'b1;
		spi_sdi       = 1'b0;
		mask_rev      = MASK_REV;
		user_irq      = 3'b000;
		lcg_state     = 32'd9;
		mirror_check  = 1'b0;
		pad_out_model = 16'h0000;
		pad_oeb_model = 16'hFFFF;
		repeat (5) @(negedge clock);
		// Control outputs idle under reset
		assert (sdo_oeb && !core_rstn && !user_clk && user_irq_ena == 3'b000 &&
			mgmt_oeb == 16'h3FFC)
		else report_mismatch("control outputs not inactive during reset");
		arst_n = 1'b1;
		repeat (4) @(negedge clock);
		assert (core_rstn)
		else report_mismatch("core_rstn_o still low after reset release");

		// Mask revision LSB first, then an unmapped address
		expect_read(ADDR_MASK_REV0, MASK_REV[7:0]);
		expect_read(ADDR_MASK_REV1, MASK_REV[15:8]);
		expect_read(ADDR_MASK_REV2, MASK_REV[23:16]);
		expect_read(ADDR_MASK_REV3, MASK_REV[31:24]);
		expect_read(7'h10, 8'h00);

		// Pad registers round trip
		out_lo = lcg_byte();
		out_hi = lcg_byte();
		oeb_lo = lcg_byte();
		oeb_hi = lcg_byte();
		write_reg(ADDR_PAD_OUT_LO, out_lo);
		write_reg(ADDR_PAD_OUT_HI, out_hi);
		write_reg(ADDR_PAD_OEB_LO, oeb_lo);
		write_reg(ADDR_PAD_OEB_HI, oeb_hi);
		pad_out_model = {out_hi, out_lo};
		pad_oeb_model = {oeb_hi, oeb_lo};
		expect_read(ADDR_PAD_OUT_LO, out_lo);
		expect_read(ADDR_PAD_OUT_HI, out_hi);
		expect_read(ADDR_PAD_OEB_LO, oeb_lo);
		expect_read(ADDR_PAD_OEB_HI, oeb_hi);
		compare_pads();

		// Enable the upper pads, then pass the SPI pins through
		write_reg(ADDR_PAD_OEB_HI, 8'h00);
		pad_oeb_model[15:8] = 8'h00;
		compare_pads();
		write_reg(ADDR_IO_CTRL, 8'h01);
		mirror_check = 1'b1;
		expect_read(ADDR_PAD_OUT_LO, out_lo);
		mirror_check = 1'b0;

		// SDO taken over by pad_out bit 1
		write_reg(ADDR_IO_CTRL, 8'h02);
		assert (sdo == pad_out_model[1] && !sdo_oeb)
		else report_mismatch("SDO override not applied");
		write_reg(ADDR_IO_CTRL, 8'h00);
		assert (sdo_oeb)
		else report_mismatch("SDO driven while CSB is high");
		compare_pads();

		// Interrupt enables and raw status
		irq_val = lcg_byte() & 8'h07;
		write_reg(ADDR_IRQ_ENA, irq_val);
		assert (user_irq_ena == irq_val[2:0])
		else report_mismatch($sformatf("user_irq_ena_o is %b, expected %b",
			user_irq_ena, irq_val[2:0]));
		user_irq = 3'b101;
		expect_read(ADDR_IRQ_STAT, 8'h05);

		// User clock divider and software reset
		write_reg(ADDR_CLK_CTRL, 8'(USER_DIV));
		measure_user_clk_high(high_clks);
		assert (high_clks == USER_DIV)
		else report_mismatch($sformatf("user_clk_o high for %0d clocks, expected %0d",
			high_clks, USER_DIV));
		write_reg(ADDR_CLK_CTRL, 8'h80 | 8'(USER_DIV));
		assert (!core_rstn)
		else report_mismatch("core_rstn_o not low under software reset");
		write_reg(ADDR_CLK_CTRL, 8'(USER_DIV));
		assert (core_rstn)
		else report_mismatch("core_rstn_o not released after software reset");
		expect_read(ADDR_CLK_CTRL, 8'(USER_DIV));

		$display("Test passed");
		$finish;
	end

endmodule

/* vlog.f */
logic/mgmt_pkg.sv
logic/hk_spi_slave.sv
logic/hk_regs.sv
logic/io_mux.sv
logic/core_clocking.sv
logic/mgmt_core.sv
tb/mgmt_core_asserts.sv
tb/tb_mgmt_core.sv
